/* Makefile */
# Verilator flow for the fetch stage testbench

VERILATOR  ?= verilator
TOP        ?= tb_fetch_stage
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert
PASS_TEXT  ?= TEST PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# result comes from the simulation output, no log kept
sim: build
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* sim.f */
verilog/fetch_pkg.sv
verilog/imem_if.sv
verilog/pc_sequencer.sv
verilog/wb_imem_master.sv
verilog/inst_queue.sv
verilog/fetch_stage.sv
verification/tb_imem_slave.sv
verification/tb_fetch_stage.sv

/* verification/tb_fetch_stage.sv */
`timescale 1ns/1ns

module tb_fetch_stage;

    localparam int num_insts     = 2000;
    localparam int wait_limit    = 200;  // cycles per instruction
    localparam int reset_cycles  = 10;

    logic        clk = 1'b0;
    logic        reset;
    logic        redirect_valid;
    logic [31:0] redirect_addr;
    logic        deq_valid;
    logic        deq_ready;
    logic [31:0] deq_addr;
    logic [31:0] deq_inst;
    logic [31:0] deq_inst_id;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_i;
    logic        wb_ack;
    logic [1:0]  ack_delay;

    logic [31:0] rnd_state = 32'hd464;
    logic [31:0] exp_addr;
    logic [31:0] exp_id;
    bit          first_seen = 1'b0;  // redirects held off until then

    int addr_errors    = 0;
    int inst_errors    = 0;
    int id_errors      = 0;
    int reset_errors   = 0;
    int bus_errors     = 0;
    int timeout_errors = 0;

    fetch_stage uut (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .deq_valid      (deq_valid),
        .deq_ready      (deq_ready),
        .deq_addr       (deq_addr),
        .deq_inst       (deq_inst),
        .deq_inst_id    (deq_inst_id),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_sel         (wb_sel),
        .wb_dat_i       (wb_dat_i),
        .wb_ack         (wb_ack)
    );

    tb_imem_slave u_mem (
        .clk       (clk),
        .reset     (reset),
        .ack_delay (ack_delay),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_o  (wb_dat_i),
        .wb_ack    (wb_ack)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // address xor pattern, rotated left by one byte
    function automatic logic [31:0] expected_inst(input logic [31:0] addr);
        logic [31:0] x;
        x = addr ^ 32'h5a5a_0000;
        return {x[23:0], x[31:24]};
    endfunction

    // random back-pressure, redirects and ack delays
    always @(posedge clk) begin
        if (!reset) begin
            rnd_state = lcg_next(rnd_state);
            deq_ready <= ((rnd_state >> 16) % 32'd10) < 32'd7;
            rnd_state = lcg_next(rnd_state);
            redirect_valid <= first_seen && (((rnd_state >> 16) % 32'd100) < 32'd3);
            rnd_state = lcg_next(rnd_state);
            redirect_addr <= {rnd_state[31:2], 2'b00};
            rnd_state = lcg_next(rnd_state);
            ack_delay <= rnd_state[31:30];
        end
    end

    // bus rules hold on every cycle
    always @(negedge clk) begin
        if (!reset && wb_we !== 1'b0) begin
            bus_errors++;
            $display("[FAIL] %0t: wb_we is %b, expected 0", $time, wb_we);
        end
        if (!reset && wb_stb === 1'b1 && wb_sel !== fetch_pkg::wb_sel_word) begin
            bus_errors++;
            $display("[FAIL] %0t: wb_sel %b during stb, expected %b", $time, wb_sel,
                     fetch_pkg::wb_sel_word);
        end
    end

    task automatic check_reset_outputs();
        @(negedge clk);
        if (deq_valid !== 1'b0 || wb_cyc !== 1'b0 || wb_stb !== 1'b0) begin
            reset_errors++;
            $display("[FAIL] %0t: after reset deq_valid %b wb_cyc %b wb_stb %b, expected 0",
                     $time, deq_valid, wb_cyc, wb_stb);
        end
        // first word needs request, bus cycle, response and push
        repeat (2) begin
            @(negedge clk);
            if (deq_valid !== 1'b0) begin
                reset_errors++;
                $display("[FAIL] %0t: deq_valid high too early after reset", $time);
            end
        end
    endtask

    // follows redirects until a plain handshake shows up
    task automatic wait_for_delivery(output bit got);
        int cycles;
        got = 1'b0;
        cycles = 0;
        while (!got && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
            if (redirect_valid) begin
                exp_addr = redirect_addr;
                exp_id   = exp_id + 32'd1;
            end else if (deq_valid && deq_ready) begin
                got = 1'b1;
            end
        end
    endtask

    task automatic check_delivery();
        if (deq_addr !== exp_addr) begin
            addr_errors++;
            $display("[FAIL] %0t: deq_addr %h, expected %h", $time, deq_addr, exp_addr);
        end
        if (deq_inst !== expected_inst(deq_addr)) begin
            inst_errors++;
            $display("[FAIL] %0t: deq_inst %h at %h, expected %h", $time, deq_inst,
                     deq_addr, expected_inst(deq_addr));
        end
        if (deq_inst_id !== exp_id) begin
            id_errors++;
            $display("[FAIL] %0t: deq_inst_id %0d, expected %0d", $time, deq_inst_id, exp_id);
        end
        exp_addr = exp_addr + 32'd4;
        exp_id   = exp_id + 32'd1;
    endtask

    initial begin
        int n;
        int total;
        bit got;
        reset          = 1'b1;
        redirect_valid = 1'b0;
        redirect_addr  = 32'h0;
        deq_ready      = 1'b0;
        ack_delay      = 2'd0;
        exp_addr       = fetch_pkg::reset_pc;
        exp_id         = 32'd0;

        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        check_reset_outputs();

        n = 0;
        got = 1'b1;
        while (got && n < num_insts) begin
            wait_for_delivery(got);
            if (got) begin
                check_delivery();
                first_seen = 1'b1;
                n++;
            end else begin
                timeout_errors++;
                $display("timeout: no instruction reached decode within %0d cycles, %0d of %0d",
                         wait_limit, n, num_insts);
            end
        end

        total = addr_errors + inst_errors + id_errors + reset_errors + bus_errors
              + timeout_errors;
        $display("errors: addr %0d, inst %0d, id %0d, reset %0d, bus %0d, timeout %0d, total %0d",
                 addr_errors, inst_errors, id_errors, reset_errors, bus_errors,
                 timeout_errors, total);
        if (total == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* verification/tb_imem_slave.sv */
`timescale 1ns/1ns

module tb_imem_slave (
    input  logic        clk,
    input  logic        reset,
    input  logic [1:0]  ack_delay,  // wait states for a cycle that starts now
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [3:0]  wb_sel,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack
);

    logic       active;  // cycle already waiting
    logic [1:0] wait_cnt;
    logic       req;

    // memory contents follow from the address alone
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] x;
        x = addr ^ 32'h5a5a_0000;
        return (x << 8) | (x >> 24);
    endfunction

    assign req    = wb_cyc && wb_stb && !wb_we && (wb_sel != 4'b0000);
    assign wb_ack = req && (active ? (wait_cnt == 2'd0) : (ack_delay == 2'd0));

    assign wb_dat_o = req ? mem_word(wb_adr) : 32'h0;

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (req && !wb_ack) begin
            if (!active) begin
                active   <= 1'b1;
                wait_cnt <= ack_delay - 2'd1;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end else begin
            active <= 1'b0;  // acked or idle
        end
    end

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

    // address and instruction width
    localparam int xlen = 32;

    // fetch queue geometry
    localparam int queue_depth = 16;
    localparam int queue_ptr_w = 4;  // log2 of queue_depth

    // running instruction id, wraps around
    localparam int inst_id_w = 32;

    // first fetch address out of reset
    localparam logic [xlen-1:0] reset_pc = 32'h0000_1000;

    // byte lanes for a full word read
    localparam logic [3:0] wb_sel_word = 4'b1111;

endpackage

/* verilog/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input  logic                            clk,
    input  logic                            reset,

    // branch mispredict from later stages
    input  logic                            redirect_valid,
    input  logic [31:0]                     redirect_addr,

    // toward decode
    output logic                            deq_valid,
    input  logic                            deq_ready,
    output logic [fetch_pkg::xlen-1:0]      deq_addr,
    output logic [fetch_pkg::xlen-1:0]      deq_inst,
    output logic [fetch_pkg::inst_id_w-1:0] deq_inst_id,

    // instruction memory, wishbone classic
    output logic                            wb_cyc,
    output logic                            wb_stb,
    output logic                            wb_we,
    output logic [fetch_pkg::xlen-1:0]      wb_adr,
    output logic [3:0]                      wb_sel,
    input  logic [fetch_pkg::xlen-1:0]      wb_dat_i,
    input  logic                            wb_ack
);

    imem_if imem ();

    logic                       space;
    logic                       push_valid;
    logic [fetch_pkg::xlen-1:0] push_addr;
    logic [fetch_pkg::xlen-1:0] push_inst;

    pc_sequencer u_seq (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .space          (space),
        .imem           (imem.seq),
        .push_valid     (push_valid),
        .push_addr      (push_addr),
        .push_inst      (push_inst)
    );

    wb_imem_master u_wb (
        .clk      (clk),
        .reset    (reset),
        .imem     (imem.mst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack)
    );

    inst_queue u_queue (
        .clk         (clk),
        .reset       (reset),
        .flush       (redirect_valid),  // redirect empties the queue
        .push_valid  (push_valid),
        .push_addr   (push_addr),
        .push_inst   (push_inst),
        .space       (space),
        .deq_valid   (deq_valid),
        .deq_ready   (deq_ready),
        .deq_addr    (deq_addr),
        .deq_inst    (deq_inst),
        .deq_inst_id (deq_inst_id)
    );

endmodule

/* verilog/imem_if.sv */
`timescale 1ns/1ns

interface imem_if;

    // request, sequencer to bus master
    logic                       req_valid;
    logic                       req_ready;
    logic [fetch_pkg::xlen-1:0] req_addr;
    logic                       req_epoch;

    // response, one cycle pulse, no ready
    logic                       resp_valid;
    logic [fetch_pkg::xlen-1:0] resp_addr;
    logic [fetch_pkg::xlen-1:0] resp_inst;
    logic                       resp_epoch;

    modport seq (
        output req_valid, req_addr, req_epoch,
        input  req_ready, resp_valid, resp_addr, resp_inst, resp_epoch
    );

    modport mst (
        input  req_valid, req_addr, req_epoch,
        output req_ready, resp_valid, resp_addr, resp_inst, resp_epoch
    );

endinterface

/* verilog/inst_queue.sv */
`timescale 1ns/1ns

module inst_queue (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            flush,
    input  logic                            push_valid,
    input  logic [fetch_pkg::xlen-1:0]      push_addr,
    input  logic [fetch_pkg::xlen-1:0]      push_inst,
    output logic                            space,
    output logic                            deq_valid,
    input  logic                            deq_ready,
    output logic [fetch_pkg::xlen-1:0]      deq_addr,
    output logic [fetch_pkg::xlen-1:0]      deq_inst,
    output logic [fetch_pkg::inst_id_w-1:0] deq_inst_id
);

    logic [fetch_pkg::xlen-1:0]      addr_mem [fetch_pkg::queue_depth];
    logic [fetch_pkg::xlen-1:0]      inst_mem [fetch_pkg::queue_depth];
    logic [fetch_pkg::queue_ptr_w-1:0] head;
    logic [fetch_pkg::queue_ptr_w-1:0] tail;
    logic [fetch_pkg::queue_ptr_w:0]   count;
    logic [fetch_pkg::inst_id_w-1:0]   inst_id;
    logic                              push;
    logic                              pop;

    // flush wins over both ends
    assign push = push_valid && !flush;
    assign pop  = deq_valid && deq_ready && !flush;

    assign deq_valid = count != '0;

    // one slot held back for the fetch that may be in flight
    assign space = count < (fetch_pkg::queue_ptr_w + 1)'(fetch_pkg::queue_depth - 1);

    assign deq_addr    = addr_mem[head];
    assign deq_inst    = inst_mem[head];
    assign deq_inst_id = inst_id;

    always_ff @(posedge clk) begin
        if (reset) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            inst_id <= '0;
        end else if (flush) begin
            head    <= tail;  // drop everything
            count   <= '0;
            inst_id <= inst_id + 1'b1;
        end else begin
            if (push)
                tail <= tail + 1'b1;
            if (pop) begin
                head    <= head + 1'b1;
                inst_id <= inst_id + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[tail] <= push_addr;
            inst_mem[tail] <= push_inst;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        push_valid |-> count != (fetch_pkg::queue_ptr_w + 1)'(fetch_pkg::queue_depth))
        else $error("inst_queue: push into a full queue");

    // nothing may slip into the queue past a flush
    assert property (@(posedge clk) disable iff (reset)
        flush |-> !push_valid)
        else $error("inst_queue: push in the same cycle as a flush");

endmodule

/* verilog/pc_sequencer.sv */
`timescale 1ns/1ns

module pc_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       redirect_valid,
    input  logic [31:0]                redirect_addr,
    input  logic                       space,
    imem_if.seq                        imem,
    output logic                       push_valid,
    output logic [fetch_pkg::xlen-1:0] push_addr,
    output logic [fetch_pkg::xlen-1:0] push_inst
);

    logic [fetch_pkg::xlen-1:0] pc;
    logic                       epoch;
    logic                       fetch_epoch;  // epoch of the word in flight
    logic                       outstanding;
    logic                       fire;

    // one fetch at a time, never on a redirect cycle
    assign imem.req_valid = !outstanding && space && !redirect_valid;
    assign imem.req_addr  = pc;
    assign imem.req_epoch = epoch;
    assign fire           = imem.req_valid && imem.req_ready;

    // a word arriving together with a redirect is from the old path too
    assign push_valid = imem.resp_valid && (imem.resp_epoch == epoch) && !redirect_valid;
    assign push_addr  = imem.resp_addr;
    assign push_inst  = imem.resp_inst;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= fetch_pkg::reset_pc;
            epoch       <= 1'b0;
            outstanding <= 1'b0;
        end else begin
            if (redirect_valid) begin
                pc <= redirect_addr;
                // two redirects during one fetch must not make it fresh again
                epoch <= outstanding ? !fetch_epoch : !epoch;
            end else if (fire) begin
                pc <= pc + 32'd4;
            end

            if (fire)
                outstanding <= 1'b1;
            else if (imem.resp_valid)
                outstanding <= 1'b0;  // stale or not
        end
    end

    always_ff @(posedge clk) begin
        if (fire)
            fetch_epoch <= epoch;
    end

    // queue keeps a slot free for the fetch in flight
    assert property (@(posedge clk) disable iff (reset)
        push_valid |-> space)
        else $error("pc_sequencer: push while queue has no space");

    // new request only once the bus master is idle again
    assert property (@(posedge clk) disable iff (reset)
        imem.req_valid |-> imem.req_ready)
        else $error("pc_sequencer: request raised with a fetch outstanding");

endmodule

/* verilog/wb_imem_master.sv */
`timescale 1ns/1ns

module wb_imem_master (
    input  logic                       clk,
    input  logic                       reset,
    imem_if.mst                        imem,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output logic [fetch_pkg::xlen-1:0] wb_adr,
    output logic [3:0]                 wb_sel,
    input  logic [fetch_pkg::xlen-1:0] wb_dat_i,
    input  logic                       wb_ack
);

    logic                       busy;  // 0 idle, 1 bus cycle open
    logic                       resp_q;
    logic [fetch_pkg::xlen-1:0] adr_q;
    logic [fetch_pkg::xlen-1:0] dat_q;
    logic                       epoch_q;
    logic                       accept;
    logic                       done;

    assign accept = !busy && imem.req_valid;
    assign done   = busy && wb_ack;

    assign imem.req_ready = !busy;

    // classic read, cyc and stb together
    assign wb_cyc = busy;
    assign wb_stb = busy;
    assign wb_we  = 1'b0;
    assign wb_adr = adr_q;
    assign wb_sel = fetch_pkg::wb_sel_word;

    assign imem.resp_valid = resp_q;
    assign imem.resp_addr  = adr_q;  // held until the next accept
    assign imem.resp_inst  = dat_q;
    assign imem.resp_epoch = epoch_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy   <= 1'b0;
            resp_q <= 1'b0;
        end else begin
            resp_q <= done;
            if (accept)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            adr_q   <= imem.req_addr;
            epoch_q <= imem.req_epoch;
        end
        if (done)
            dat_q <= wb_dat_i;
    end

    // address held until the slave acks
    assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
        else $error("wb_imem_master: cycle dropped or address changed before ack");

endmodule
